/* sources.f */
l2c_pkg.sv
l2c_req_fifo.sv
l2c_line_mem.sv
l2c_latency_timer.sv
l2c_ctrl_fsm.sv
l2c_emulator.sv
tb_l2c_emulator.sv

/* tb_l2c_emulator.sv */
// L2 cache emulator testbench

`default_nettype none
`timescale 1ns/100ps

module tb_l2c_emulator;

    localparam int unsigned FIFO_DEPTH = 4;
    localparam int unsigned LATENCY    = 3;
    localparam int unsigned N_RAND     = 40;
    // Requests issued over all tests
    localparam int unsigned TEST_REQS  = 1 + N_RAND + 1 + (FIFO_DEPTH + 2) + 4;
    localparam int unsigned WATCHDOG_CYCLES = TEST_REQS * (LATENCY + 1) * 4 + 200;

    logic               clk;
    logic               rst_i;
    logic               flush_i;
    logic               req_valid_i;
    l2c_pkg::l2c_op_t   req_op_i;
    l2c_pkg::l2c_addr_t req_addr_i;
    l2c_pkg::l2c_line_t req_data_i;
    logic               req_rdy_o;
    logic               ans_valid_o;
    l2c_pkg::l2c_op_t   ans_op_o;
    l2c_pkg::l2c_addr_t ans_addr_o;
    l2c_pkg::l2c_line_t ans_data_o;
    logic               ans_rdy_i;

    // ----------------------------------------
    // Reference model state
    // ----------------------------------------
    l2c_pkg::l2c_line_t mem_m [64];
    logic [63:0]        vld_m;
    // Ring of expected answers in acceptance order
    l2c_pkg::l2c_op_t   exp_op_a   [16];
    l2c_pkg::l2c_addr_t exp_addr_a [16];
    l2c_pkg::l2c_line_t exp_data_a [16];
    int unsigned        exp_wr;
    int unsigned        exp_rd;
    int unsigned        exp_cnt;
    l2c_pkg::l2c_op_t   exp_op_h;
    l2c_pkg::l2c_addr_t exp_addr_h;
    l2c_pkg::l2c_line_t exp_data_h;
    l2c_pkg::l2c_line_t last_data;
    logic               ans_xfer;

    int          err_cnt  = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    // 0 holds ans_rdy_i low, 1 holds it high, 2 randomizes it
    int          rdy_mode = 1;
    logic [31:0] rng      = 32'd65201;
    logic [31:0] rdy_rng  = 32'd65201;

    assign exp_cnt    = exp_wr - exp_rd;
    assign exp_op_h   = exp_op_a[exp_rd % 16];
    assign exp_addr_h = exp_addr_a[exp_rd % 16];
    assign exp_data_h = exp_data_a[exp_rd % 16];
    assign ans_xfer   = ans_valid_o && ans_rdy_i && !flush_i;

    l2c_emulator #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .LATENCY    (LATENCY)
    ) u_l2c_emulator (
        .clk         (clk),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .req_data_i  (req_data_i),
        .req_rdy_o   (req_rdy_o),
        .ans_valid_o (ans_valid_o),
        .ans_op_o    (ans_op_o),
        .ans_addr_o  (ans_addr_o),
        .ans_data_o  (ans_data_o),
        .ans_rdy_i   (ans_rdy_i)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Model follows accepted requests in order, flush wipes it
    always @(posedge clk) begin
        last_data <= ans_data_o;
        if (rst_i || flush_i) begin
            vld_m  = '0;
            exp_wr = 0;
            exp_rd = 0;
        end else begin
            if (ans_valid_o && ans_rdy_i) begin
                exp_rd = exp_rd + 1;
            end
            if (req_valid_i && req_rdy_o) begin
                exp_op_a[exp_wr % 16]   = req_op_i;
                exp_addr_a[exp_wr % 16] = req_addr_i;
                if (req_op_i == l2c_pkg::OP_WRITE) begin
                    mem_m[req_addr_i]      = req_data_i;
                    vld_m[req_addr_i]      = 1'b1;
                    exp_data_a[exp_wr % 16] = req_data_i;
                end else begin
                    exp_data_a[exp_wr % 16] = vld_m[req_addr_i] ? mem_m[req_addr_i] : '0;
                end
                exp_wr = exp_wr + 1;
            end
        end
    end

    // Answer-side ready pattern
    always @(posedge clk) begin
        rdy_rng = xorshift32(rdy_rng);
        if (rdy_mode == 2) begin
            ans_rdy_i <= rdy_rng[7];
        end else begin
            ans_rdy_i <= (rdy_mode == 1);
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    answer_expected_a : assert property (@(posedge clk) disable iff (rst_i)
        ans_xfer |-> exp_cnt != 0)
        else begin
            err_cnt++;
            $display("Answer at %0t with no request outstanding", $time);
        end

    ans_op_a : assert property (@(posedge clk) disable iff (rst_i)
        ans_xfer && exp_cnt != 0 |-> ans_op_o == exp_op_h)
        else begin
            err_cnt++;
            $display("[FAIL] t=%0t ans_op_o expected %h got %h", $time,
                $sampled(exp_op_h), $sampled(ans_op_o));
        end

    ans_addr_a : assert property (@(posedge clk) disable iff (rst_i)
        ans_xfer && exp_cnt != 0 |-> ans_addr_o == exp_addr_h)
        else begin
            err_cnt++;
            $display("[FAIL] t=%0t ans_addr_o expected %h got %h", $time,
                $sampled(exp_addr_h), $sampled(ans_addr_o));
        end

    ans_data_a : assert property (@(posedge clk) disable iff (rst_i)
        ans_xfer && exp_cnt != 0 |-> ans_data_o == exp_data_h)
        else begin
            err_cnt++;
            $display("[FAIL] t=%0t ans_data_o expected %h got %h", $time,
                $sampled(exp_data_h), $sampled(ans_data_o));
        end

    // Held answer must not move under back-pressure
    ans_hold_a : assert property (@(posedge clk) disable iff (rst_i || flush_i)
        ans_valid_o && !ans_rdy_i |=> ans_data_o == last_data)
        else begin
            err_cnt++;
            $display("[FAIL] t=%0t ans_data_o expected %h got %h", $time,
                $sampled(last_data), $sampled(ans_data_o));
        end

    // Idle acceptance sees the answer after exactly LATENCY+1 cycles
    latency_a : assert property (@(posedge clk) disable iff (rst_i || flush_i)
        req_valid_i && req_rdy_o && exp_cnt == 0
        |=> (!ans_valid_o) [* LATENCY + 1] ##1 ans_valid_o)
        else begin
            err_cnt++;
            $display("ans_valid_o missed the fixed latency at %0t", $time);
        end

    // At most FIFO_DEPTH queued plus one in service
    rdy_limit_a : assert property (@(posedge clk) disable iff (rst_i)
        req_rdy_o |-> exp_cnt <= FIFO_DEPTH)
        else begin
            err_cnt++;
            $display("[FAIL] t=%0t req_rdy_o expected %b got %b", $time,
                1'b0, $sampled(req_rdy_o));
        end

    reset_state_a : assert property (@(posedge clk)
        $fell(rst_i) |-> !ans_valid_o && req_rdy_o)
        else begin
            err_cnt++;
            $display("Wrong handshake state after reset at %0t", $time);
        end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic send_req(input l2c_pkg::l2c_op_t op, input l2c_pkg::l2c_addr_t addr,
                            input l2c_pkg::l2c_line_t data);
        req_valid_i <= 1'b1;
        req_op_i    <= op;
        req_addr_i  <= addr;
        req_data_i  <= data;
        @(posedge clk);
        while (!req_rdy_o) begin
            @(posedge clk);
        end
        req_valid_i <= 1'b0;
    endtask

    task automatic drain_answers();
        while (exp_cnt != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
    endtask

    task automatic report_test(input string name, input int err_start);
        if (err_cnt == err_start) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, err_cnt - err_start);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int                 err_start;
        l2c_pkg::l2c_line_t data;
        rst_i       = 1'b1;
        flush_i     = 1'b0;
        req_valid_i = 1'b0;
        req_op_i    = l2c_pkg::OP_READ;
        req_addr_i  = '0;
        req_data_i  = '0;
        ans_rdy_i   = 1'b0;
        repeat (3) @(posedge clk);
        rst_i <= 1'b0;
        repeat (2) @(posedge clk);
        report_test("reset state", 0);

        // Unwritten line reads zero
        err_start = err_cnt;
        send_req(l2c_pkg::OP_READ, 6'h2a, 64'hdead_beef_0bad_f00d);
        drain_answers();
        report_test("cold read", err_start);

        // Small index range so reads hit earlier writes
        err_start = err_cnt;
        rdy_mode  <= 2;
        for (int i = 0; i < N_RAND; i++) begin
            rng  = xorshift32(rng);
            data[63:32] = rng;
            rng  = xorshift32(rng);
            data[31:0]  = rng;
            send_req(l2c_pkg::l2c_op_t'(rng[9]), {3'b000, rng[2:0]}, data);
        end
        drain_answers();
        report_test("random traffic", err_start);

        err_start = err_cnt;
        rdy_mode  <= 1;
        send_req(l2c_pkg::OP_READ, 6'h03, '0);
        drain_answers();
        report_test("idle latency", err_start);

        // Fill queue and server, then one more waits on req_rdy_o
        err_start = err_cnt;
        rdy_mode  <= 0;
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            send_req(l2c_pkg::l2c_op_t'(i % 2), 6'(i), {32'hcafe_0000, 32'(i)});
        end
        fork
            send_req(l2c_pkg::OP_READ, 6'h00, '0);
            begin
                repeat (8) @(posedge clk);
                rdy_mode <= 1;
            end
        join
        drain_answers();
        report_test("back-pressure", err_start);

        err_start = err_cnt;
        send_req(l2c_pkg::OP_WRITE, 6'h05, 64'h0123_4567_89ab_cdef);
        drain_answers();
        rdy_mode <= 0;
        send_req(l2c_pkg::OP_READ, 6'h05, '0);
        send_req(l2c_pkg::OP_WRITE, 6'h06, 64'h1111_2222_3333_4444);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i  <= 1'b0;
        rdy_mode <= 1;
        repeat (LATENCY + 4) @(posedge clk);
        send_req(l2c_pkg::OP_READ, 6'h05, '0);
        drain_answers();
        report_test("flush", err_start);

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* l2c_emulator.sv */
// L2 cache memory emulator top level

`default_nettype none
`timescale 1ns/100ps

module l2c_emulator #(
    parameter int unsigned FIFO_DEPTH = 4,
    parameter int unsigned LATENCY    = 3
) (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire                     flush_i,
    // Request channel
    input  wire                     req_valid_i,
    input  wire l2c_pkg::l2c_op_t   req_op_i,
    input  wire l2c_pkg::l2c_addr_t req_addr_i,
    input  wire l2c_pkg::l2c_line_t req_data_i,
    output logic                    req_rdy_o,
    // Answer channel
    output logic                    ans_valid_o,
    output l2c_pkg::l2c_op_t        ans_op_o,
    output l2c_pkg::l2c_addr_t      ans_addr_o,
    output l2c_pkg::l2c_line_t      ans_data_o,
    input  wire                     ans_rdy_i
);

    // ----------------------------------------
    // Internal wiring
    // ----------------------------------------
    logic               fifo_full;
    logic               fifo_empty;
    logic               fifo_push;
    logic               fifo_pop;
    l2c_pkg::l2c_op_t   head_op;
    l2c_pkg::l2c_addr_t head_addr;
    l2c_pkg::l2c_line_t head_data;
    logic               tmr_start;
    logic               tmr_done;
    logic               mem_wr_en;
    l2c_pkg::l2c_addr_t mem_addr;
    l2c_pkg::l2c_line_t mem_wr_data;
    l2c_pkg::l2c_line_t mem_rd_data;

    // No acceptance in a flush cycle
    assign req_rdy_o = !fifo_full && !flush_i;
    assign fifo_push = req_valid_i && req_rdy_o;

    // Request queue
    l2c_req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_req_fifo (
        .clk         (clk),
        .rst_i       (rst_i),
        .clear_i     (flush_i),
        .push_i      (fifo_push),
        .push_op_i   (req_op_i),
        .push_addr_i (req_addr_i),
        .push_data_i (req_data_i),
        .full_o      (fifo_full),
        .pop_i       (fifo_pop),
        .empty_o     (fifo_empty),
        .head_op_o   (head_op),
        .head_addr_o (head_addr),
        .head_data_o (head_data)
    );

    // Backing store, same index for write and read
    l2c_line_mem u_line_mem (
        .clk       (clk),
        .rst_i     (rst_i),
        .clear_i   (flush_i),
        .wr_en_i   (mem_wr_en),
        .wr_addr_i (mem_addr),
        .wr_data_i (mem_wr_data),
        .rd_addr_i (mem_addr),
        .rd_data_o (mem_rd_data)
    );

    l2c_latency_timer #(
        .LATENCY (LATENCY)
    ) u_latency_timer (
        .clk     (clk),
        .rst_i   (rst_i),
        .start_i (tmr_start),
        .done_o  (tmr_done)
    );

    // Sequencing of pop, wait and answer
    l2c_ctrl_fsm u_ctrl_fsm (
        .clk           (clk),
        .rst_i         (rst_i),
        .flush_i       (flush_i),
        .fifo_empty_i  (fifo_empty),
        .head_op_i     (head_op),
        .head_addr_i   (head_addr),
        .head_data_i   (head_data),
        .pop_o         (fifo_pop),
        .tmr_start_o   (tmr_start),
        .tmr_done_i    (tmr_done),
        .mem_wr_en_o   (mem_wr_en),
        .mem_addr_o    (mem_addr),
        .mem_wr_data_o (mem_wr_data),
        .mem_rd_data_i (mem_rd_data),
        .ans_valid_o   (ans_valid_o),
        .ans_op_o      (ans_op_o),
        .ans_addr_o    (ans_addr_o),
        .ans_data_o    (ans_data_o),
        .ans_rdy_i     (ans_rdy_i)
    );

endmodule

`default_nettype wire

/* l2c_ctrl_fsm.sv */
// Request service controller

`default_nettype none
`timescale 1ns/100ps

module l2c_ctrl_fsm (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire                     flush_i,
    // Queue head
    input  wire                     fifo_empty_i,
    input  wire l2c_pkg::l2c_op_t   head_op_i,
    input  wire l2c_pkg::l2c_addr_t head_addr_i,
    input  wire l2c_pkg::l2c_line_t head_data_i,
    output logic                    pop_o,
    // Latency timer
    output logic                    tmr_start_o,
    input  wire                     tmr_done_i,
    // Line memory
    output logic                    mem_wr_en_o,
    output l2c_pkg::l2c_addr_t      mem_addr_o,
    output l2c_pkg::l2c_line_t      mem_wr_data_o,
    input  wire l2c_pkg::l2c_line_t mem_rd_data_i,
    // Answer channel
    output logic                    ans_valid_o,
    output l2c_pkg::l2c_op_t        ans_op_o,
    output l2c_pkg::l2c_addr_t      ans_addr_o,
    output l2c_pkg::l2c_line_t      ans_data_o,
    input  wire                     ans_rdy_i
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        ANSWER
    } state_t;

    state_t state_q;
    state_t state_d;

    // Request being served
    l2c_pkg::l2c_op_t   hold_op_q;
    l2c_pkg::l2c_addr_t hold_addr_q;
    l2c_pkg::l2c_line_t hold_data_q;

    logic ans_load;

    // ----------------------------------------
    // Control outputs
    // ----------------------------------------

    // Pop whenever idle with work queued
    assign pop_o       = (state_q == IDLE) && !fifo_empty_i;
    // A pop cancelled by flush starts no timer run
    assign tmr_start_o = pop_o && !flush_i;
    assign ans_load    = (state_q == WAIT) && tmr_done_i;

    // Write goes to memory on the pop edge
    assign mem_wr_en_o   = pop_o && (head_op_i == l2c_pkg::OP_WRITE);
    assign mem_wr_data_o = head_data_i;
    // Head index while idle, held index for the read in WAIT
    assign mem_addr_o    = (state_q == IDLE) ? head_addr_i : hold_addr_q;

    // Answer is valid exactly in ANSWER
    assign ans_valid_o = (state_q == ANSWER);

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (!fifo_empty_i) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                if (tmr_done_i) begin
                    state_d = ANSWER;
                end
            end
            ANSWER: begin
                if (ans_rdy_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
        // Flush drops whatever is in service
        if (flush_i) begin
            state_d = IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Hold registers loaded on pop
    always_ff @(posedge clk) begin
        if (pop_o) begin
            hold_op_q   <= head_op_i;
            hold_addr_q <= head_addr_i;
            hold_data_q <= head_data_i;
        end
    end

    // Answer latch, held under back-pressure
    always_ff @(posedge clk) begin
        if (ans_load) begin
            ans_op_o   <= hold_op_q;
            ans_addr_o <= hold_addr_q;
            if (hold_op_q == l2c_pkg::OP_READ) begin
                ans_data_o <= mem_rd_data_i;
            end else begin
                ans_data_o <= hold_data_q;
            end
        end
    end

    // Pending answer held until taken or flushed
    ans_stable_a : assert property (@(posedge clk) disable iff (rst_i)
        ans_valid_o && !ans_rdy_i && !flush_i
        |=> ans_valid_o && $stable(ans_op_o) && $stable(ans_addr_o)
            && $stable(ans_data_o))
        else $error("l2c_ctrl_fsm: answer changed under back-pressure");

endmodule

`default_nettype wire

/* l2c_latency_timer.sv */
// Access latency timer

`default_nettype none
`timescale 1ns/100ps

module l2c_latency_timer #(
    parameter int unsigned LATENCY = 3
) (
    input  wire  clk,
    input  wire  rst_i,
    input  wire  start_i,
    output logic done_o
);

    // Counter holds at most LATENCY-1
    localparam int unsigned CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

    if (LATENCY < 1) begin : g_latency_check
        $error("l2c_latency_timer: LATENCY must be at least 1");
    end

    logic [CNT_W-1:0] cnt_q;
    logic             running_q;

    // Start reloads, even over a run abandoned by a flush
    always_ff @(posedge clk) begin
        if (rst_i) begin
            running_q <= 1'b0;
            cnt_q     <= '0;
        end else if (start_i) begin
            running_q <= 1'b1;
            cnt_q     <= CNT_W'(LATENCY - 1);
        end else if (running_q) begin
            if (cnt_q == '0) begin
                running_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q - CNT_W'(1);
            end
        end
    end

    // Single-cycle pulse at end of count
    assign done_o = running_q && (cnt_q == '0);

    // Restart only when idle or in the final count cycle
    start_not_running_a : assert property (@(posedge clk) disable iff (rst_i)
        start_i |-> !running_q || done_o)
        else $error("l2c_latency_timer: start while running");

endmodule

`default_nettype wire

/* l2c_line_mem.sv */
// Line storage with valid bits

`default_nettype none
`timescale 1ns/100ps

module l2c_line_mem (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire                     clear_i,
    input  wire                     wr_en_i,
    input  wire l2c_pkg::l2c_addr_t wr_addr_i,
    input  wire l2c_pkg::l2c_line_t wr_data_i,
    input  wire l2c_pkg::l2c_addr_t rd_addr_i,
    output l2c_pkg::l2c_line_t      rd_data_o
);

    // One entry per line index
    localparam int unsigned NUM_LINES = 1 << l2c_pkg::LINE_IDX_W;

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    // Data array, contents only meaningful where valid
    l2c_pkg::l2c_line_t line_q [NUM_LINES];

    // One valid bit per line
    logic [NUM_LINES-1:0] valid_q;

    // Data write
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            line_q[wr_addr_i] <= wr_data_i;
        end
    end

    // ----------------------------------------
    // Valid bits
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i || clear_i) begin
            // Invalidate everything in a single cycle
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_addr_i] <= 1'b1;
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------

    // Asynchronous read
    // Invalid lines read back as zero
    always_comb begin
        if (valid_q[rd_addr_i]) begin
            rd_data_o = line_q[rd_addr_i];
        end else begin
            rd_data_o = '0;
        end
    end

endmodule

`default_nettype wire

/* l2c_req_fifo.sv */
// Request queue

`default_nettype none
`timescale 1ns/100ps

module l2c_req_fifo #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  wire                  clk,
    input  wire                  rst_i,
    input  wire                  clear_i,
    input  wire                  push_i,
    input  wire l2c_pkg::l2c_op_t   push_op_i,
    input  wire l2c_pkg::l2c_addr_t push_addr_i,
    input  wire l2c_pkg::l2c_line_t push_data_i,
    output logic                 full_o,
    input  wire                  pop_i,
    output logic                 empty_o,
    output l2c_pkg::l2c_op_t     head_op_o,
    output l2c_pkg::l2c_addr_t   head_addr_o,
    output l2c_pkg::l2c_line_t   head_data_o
);

    // Pointer needs at least one bit even for a single entry
    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    // Entry storage, no reset needed
    l2c_pkg::l2c_op_t   op_mem   [FIFO_DEPTH];
    l2c_pkg::l2c_addr_t addr_mem [FIFO_DEPTH];
    l2c_pkg::l2c_line_t data_mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    // Wrap at FIFO_DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i || clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // Simultaneous push and pop leaves count unchanged
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    // Write port
    always_ff @(posedge clk) begin
        if (push_i) begin
            op_mem[wr_ptr_q]   <= push_op_i;
            addr_mem[wr_ptr_q] <= push_addr_i;
            data_mem[wr_ptr_q] <= push_data_i;
        end
    end

    // Status and head of queue
    assign full_o      = (count_q == CNT_W'(FIFO_DEPTH));
    assign empty_o     = (count_q == '0);
    assign head_op_o   = op_mem[rd_ptr_q];
    assign head_addr_o = addr_mem[rd_ptr_q];
    assign head_data_o = data_mem[rd_ptr_q];

    // Top level must gate pushes with full
    push_not_full_a : assert property (@(posedge clk) disable iff (rst_i)
        push_i |-> !full_o)
        else $error("l2c_req_fifo: push while full");

    // FSM must only pop a non-empty queue
    pop_not_empty_a : assert property (@(posedge clk) disable iff (rst_i)
        pop_i |-> !empty_o)
        else $error("l2c_req_fifo: pop while empty");

endmodule

`default_nettype wire

/* l2c_pkg.sv */
// L2 cache emulator shared definitions

`default_nettype none

package l2c_pkg;

    // ----------------------------------------
    // Geometry
    // ----------------------------------------

    // Line index width, 64 lines in total
    localparam int unsigned LINE_IDX_W = 6;

    // One cache line of payload
    localparam int unsigned LINE_W = 64;

    // ----------------------------------------
    // Vector types
    // ----------------------------------------

    // Line index carried by requests and answers
    typedef logic [LINE_IDX_W-1:0] l2c_addr_t;

    // Full data line
    typedef logic [LINE_W-1:0] l2c_line_t;

    // Request operation
    typedef logic [0:0] l2c_op_t;

    // ----------------------------------------
    // Operation codes
    // ----------------------------------------

    // Read returns the stored line, or zero if never written
    localparam l2c_op_t OP_READ = 1'b0;

    // Write echoes the written line back as acknowledgement
    localparam l2c_op_t OP_WRITE = 1'b1;

endpackage

`default_nettype wire
